/* common/edm_settings.svh */
`ifndef EDM_SETTINGS_SVH
`define EDM_SETTINGS_SVH

// buck phase array
`define EDM_PHASES      2       // 1 to 4 phases
`define EDM_DEAD_TIME   4       // both-off cycles between switch changes
`define EDM_INTERLEAVE  3       // enable stagger per phase
`define EDM_HYST        4       // current band below ip

// breakdown detection
`define EDM_WAIT_MIN    20      // earlier breakdown counts as arc
`define EDM_WAIT_MAX    200     // no breakdown by then means open
`define EDM_V_BREAK     30      // gap voltage under this is breakdown
`define EDM_V_SHORT     5       // under this on entry is a short

`define EDM_STAT_WINDOW 15      // pulses per feedback word

// spi register map
`define EDM_ADDR_TON    7'd0
`define EDM_ADDR_TOFF   7'd1
`define EDM_ADDR_IP     7'd2
`define EDM_ADDR_CTRL   7'd3    // bit0 start, bit1 stop, bit2 single
`define EDM_ADDR_FB     7'd4    // read only

`endif

/* common/edm_pkg.sv */
package edm_pkg;

    typedef logic [15:0] sample_t;  // one adc word, voltage or current
    typedef logic [15:0] time_t;    // cycle count for ton, toff, wait
    typedef logic [1:0]  gate_t;    // [1] upper switch, [0] lower switch

    // how a finished pulse ended
    typedef enum logic [1:0] {
        PULSE_NORMAL = 2'd0,        // breakdown after the min delay
        PULSE_ARC    = 2'd1,        // breakdown too early
        PULSE_OPEN   = 2'd2,        // no breakdown at all
        PULSE_SHORT  = 2'd3         // gap already collapsed
    } pulse_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,        // machine stopped
        ST_WAIT      = 2'd1,        // gap voltage applied
        ST_DISCHARGE = 2'd2,        // ton window, buck phases run
        ST_DEION     = 2'd3         // toff window
    } seq_state_e;

    typedef struct packed {
        time_t   ton;               // discharge cycles
        time_t   toff;              // deion cycles
        sample_t ip;                // peak current target
        logic    single_mode;       // stop after one pulse
    } edm_cfg_s;

    typedef struct packed {
        logic        valid;         // one cycle per finished pulse
        pulse_kind_e kind;
    } pulse_event_s;

endpackage

/* verilog/spi_cmd_slave.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module spi_cmd_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sclk,
    input  logic              cs_n,
    input  logic              mosi,
    output logic              miso,
    input  logic [15:0]       feedback,
    output edm_pkg::edm_cfg_s cfg,
    output logic              start_req,
    output logic              stop_req
);
    import edm_pkg::*;

    logic [2:0]  sclk_q;        // 2-flop sync plus one for edges
    logic [2:0]  cs_q;          // same depth as sclk
    logic [1:0]  mosi_q;        // lines up with sclk_q[1]
    logic        sclk_rise;
    logic        sclk_fall;
    logic        cs_fall;
    logic        cs_rise;
    logic [23:0] frame;         // rw, addr[6:0], data[15:0]
    logic [4:0]  bit_cnt;       // saturates at 31
    logic [15:0] tx_shift;      // read data still to send
    logic [15:0] rd_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_q <= '0;
            cs_q   <= '1;       // deselected
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], sclk};
            cs_q   <= {cs_q[1:0], cs_n};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    assign cs_rise   = cs_q[1] & ~cs_q[2];

    // read mux, valid once rw and address are in frame[7:0]
    always_comb begin
        rd_word = '0;
        if (frame[7]) begin
            case (frame[6:0])
                `EDM_ADDR_TON:  rd_word = cfg.ton;
                `EDM_ADDR_TOFF: rd_word = cfg.toff;
                `EDM_ADDR_IP:   rd_word = cfg.ip;
                `EDM_ADDR_CTRL: rd_word = {13'd0, cfg.single_mode, 2'b00};
                `EDM_ADDR_FB:   rd_word = feedback;
                default:        rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame    <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            miso     <= 1'b0;
        end else if (cs_fall) begin         // new frame
            frame    <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            miso     <= 1'b0;
        end else if (!cs_q[1]) begin
            if (sclk_rise) begin
                frame <= {frame[22:0], mosi_q[1]};  // msb first
                if (bit_cnt != 5'd31) begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
            end else if (sclk_fall) begin
                if (bit_cnt == 5'd8) begin          // header done, load read data
                    miso     <= rd_word[15];
                    tx_shift <= {rd_word[14:0], 1'b0};
                end else begin
                    miso     <= tx_shift[15];
                    tx_shift <= {tx_shift[14:0], 1'b0};
                end
            end
        end else begin
            miso <= 1'b0;                   // idle low between frames
        end
    end

    // writes take effect on cs_n rise, full 24-bit frames only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg       <= '0;
            start_req <= 1'b0;
            stop_req  <= 1'b0;
        end else begin
            start_req <= 1'b0;
            stop_req  <= 1'b0;
            if (cs_rise && bit_cnt == 5'd24 && !frame[23]) begin
                case (frame[22:16])
                    `EDM_ADDR_TON:  cfg.ton  <= time_t'(frame[15:0]);
                    `EDM_ADDR_TOFF: cfg.toff <= time_t'(frame[15:0]);
                    `EDM_ADDR_IP:   cfg.ip   <= sample_t'(frame[15:0]);
                    `EDM_ADDR_CTRL: begin
                        cfg.single_mode <= frame[2];
                        start_req       <= frame[0];    // one-cycle pulses
                        stop_req        <= frame[1];
                    end
                    default: ;                          // feedback is read only
                endcase
            end
        end
    end

endmodule

/* discharge/discharge_sequencer.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module discharge_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  edm_pkg::edm_cfg_s      cfg,
    input  logic                   start_req,
    input  logic                   stop_req,
    input  edm_pkg::sample_t       sample_voltage,
    output logic [`EDM_PHASES-1:0] phase_en,
    output edm_pkg::sample_t       ip_target,
    output edm_pkg::pulse_event_s  pulse_event,
    output logic                   mosfet_deion,
    output logic                   is_breakdown,
    output logic                   operation
);
    import edm_pkg::*;

    seq_state_e  state;
    seq_state_e  state_nxt;
    time_t       cnt;           // wait delay, ton or toff, restarts per state
    sample_t     v_q;           // registered gap voltage
    logic        short_now;     // low gap on the first wait cycle
    logic        stop_pend;     // stop seen, finish current pulse
    pulse_kind_e kind_q;
    pulse_kind_e kind_nxt;
    logic        v_break;
    logic        wait_done;
    logic        ton_done;
    logic        toff_done;

    assign v_break   = v_q < sample_t'(`EDM_V_BREAK);
    assign short_now = (cnt == '0) && (v_q < sample_t'(`EDM_V_SHORT));
    assign wait_done = cnt >= time_t'(`EDM_WAIT_MAX - 1);
    assign ton_done  = (17'(cnt) + 17'd1) >= 17'(cfg.ton);     // ton of 0 acts as 1
    assign toff_done = (17'(cnt) + 17'd1) >= 17'(cfg.toff);

    always_comb begin
        state_nxt = state;
        kind_nxt  = kind_q;
        case (state)
            ST_IDLE: begin
                if (start_req) begin
                    state_nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (v_break) begin                  // breakdown, cnt is the delay
                    state_nxt = ST_DISCHARGE;
                    if (short_now) begin
                        kind_nxt = PULSE_SHORT;
                    end else if (cnt < time_t'(`EDM_WAIT_MIN)) begin
                        kind_nxt = PULSE_ARC;
                    end else begin
                        kind_nxt = PULSE_NORMAL;
                    end
                end else if (wait_done) begin       // gap never broke down
                    state_nxt = ST_DEION;
                    kind_nxt  = PULSE_OPEN;
                end
            end
            ST_DISCHARGE: begin
                if (ton_done) begin
                    state_nxt = ST_DEION;
                end
            end
            ST_DEION: begin
                if (toff_done) begin
                    if (stop_pend || stop_req || cfg.single_mode) begin
                        state_nxt = ST_IDLE;
                    end else begin
                        state_nxt = ST_WAIT;        // next pulse
                    end
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            v_q         <= '0;
            stop_pend   <= 1'b0;
            kind_q      <= PULSE_NORMAL;
            pulse_event <= '0;
            ip_target   <= '0;
        end else begin
            state  <= state_nxt;
            kind_q <= kind_nxt;
            v_q    <= sample_voltage;
            if (state_nxt != state || state == ST_IDLE) begin
                cnt <= '0;                          // each state counts from zero
            end else begin
                cnt <= cnt + time_t'(1);
            end
            if (state_nxt == ST_IDLE) begin
                stop_pend <= 1'b0;
            end else if (stop_req && state != ST_IDLE) begin
                stop_pend <= 1'b1;
            end
            pulse_event.valid <= (state_nxt == ST_DEION) && (state != ST_DEION);
            pulse_event.kind  <= kind_nxt;
            if (state == ST_WAIT && state_nxt == ST_DISCHARGE) begin
                ip_target <= cfg.ip;                // held for the whole ton
            end
        end
    end

    assign operation    = state != ST_IDLE;
    assign is_breakdown = state == ST_DISCHARGE;
    assign mosfet_deion = state == ST_DEION;

    // phase k joins k*interleave cycles into the discharge
    always_comb begin
        for (int k = 0; k < `EDM_PHASES; k++) begin
            phase_en[k] = is_breakdown && (cnt >= time_t'(k * `EDM_INTERLEAVE));
        end
    end

endmodule

/* discharge/buck_phase.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module buck_phase (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  edm_pkg::sample_t ip_target,
    input  edm_pkg::sample_t current,
    output edm_pkg::gate_t   gate
);
    import edm_pkg::*;

    localparam gate_t GATE_OFF   = 2'b00;
    localparam gate_t GATE_UPPER = 2'b10;     // charge the inductor
    localparam gate_t GATE_LOWER = 2'b01;     // freewheel
    localparam int    DEAD_W     = $clog2(`EDM_DEAD_TIME + 1);

    gate_t             gate_q;
    gate_t             side_q;      // switch the band last asked for
    gate_t             side_nxt;
    logic [DEAD_W-1:0] dead_cnt;    // consecutive both-off cycles
    logic              dead_done;
    logic              cur_low;
    logic              cur_high;

    assign cur_low   = (17'(current) + 17'(`EDM_HYST)) < 17'(ip_target);
    assign cur_high  = current > ip_target;
    assign dead_done = dead_cnt >= DEAD_W'(`EDM_DEAD_TIME - 1);

    // hysteresis, hold the side inside the band
    always_comb begin
        side_nxt = side_q;
        if (cur_low) begin
            side_nxt = GATE_UPPER;
        end else if (cur_high) begin
            side_nxt = GATE_LOWER;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gate_q   <= GATE_OFF;
            side_q   <= GATE_UPPER;
            dead_cnt <= '0;
        end else begin
            side_q <= side_nxt;
            if (gate_q != GATE_OFF) begin
                dead_cnt <= '0;
            end else if (!dead_done) begin
                dead_cnt <= dead_cnt + 1'b1;
            end
            if (!en) begin
                gate_q <= GATE_OFF;
            end else if (gate_q == GATE_OFF) begin
                if (dead_done) begin
                    gate_q <= side_nxt;     // dead time served, switch on
                end
            end else if (gate_q != side_nxt) begin
                gate_q <= GATE_OFF;         // change of side starts dead time
            end
        end
    end

    // both switches drop in the same cycle as the enable
    assign gate = en ? gate_q : GATE_OFF;

endmodule

/* verilog/pulse_statistic.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module pulse_statistic (
    input  logic                  clk,
    input  logic                  rst_n,
    input  edm_pkg::pulse_event_s pulse_event,
    output logic [15:0]           feedback
);
    import edm_pkg::*;

    logic [3:0][3:0] kind_cnt;      // indexed by pulse_kind_e
    logic [3:0][3:0] cnt_nxt;
    logic [3:0]      win_cnt;       // events in the current window
    logic            win_end;

    // count the incoming kind, 15 per window fits in 4 bits
    always_comb begin
        cnt_nxt = kind_cnt;
        cnt_nxt[pulse_event.kind] = kind_cnt[pulse_event.kind] + 4'd1;
    end

    assign win_end = win_cnt == 4'(`EDM_STAT_WINDOW - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind_cnt <= '0;
            win_cnt  <= '0;
            feedback <= '0;
        end else if (pulse_event.valid) begin
            if (win_end) begin
                // normal, arc, open, short from the top nibble down
                feedback <= {cnt_nxt[PULSE_NORMAL],
                             cnt_nxt[PULSE_ARC],
                             cnt_nxt[PULSE_OPEN],
                             cnt_nxt[PULSE_SHORT]};
                kind_cnt <= '0;             // fresh window
                win_cnt  <= '0;
            end else begin
                kind_cnt <= cnt_nxt;
                win_cnt  <= win_cnt + 4'd1;
            end
        end
    end

endmodule

/* verilog/edm_pulse_slave.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module edm_pulse_slave (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sclk,
    input  logic                               cs_n,
    input  logic                               mosi,
    output logic                               miso,
    input  edm_pkg::sample_t                   sample_voltage,
    input  edm_pkg::sample_t [`EDM_PHASES-1:0] phase_current,
    output edm_pkg::gate_t [`EDM_PHASES-1:0]   gates,
    output logic                               mosfet_deion,
    output logic                               is_breakdown,
    output logic                               operation
);
    import edm_pkg::*;

    edm_cfg_s               cfg;            // host settings
    pulse_event_s           pulse_event;    // one per finished pulse
    sample_t                ip_target;
    logic [15:0]            feedback;
    logic                   start_req;
    logic                   stop_req;
    logic [`EDM_PHASES-1:0] phase_en;       // staggered by the sequencer

    spi_cmd_slave spi_cmd_slave_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .feedback  (feedback),
        .cfg       (cfg),
        .start_req (start_req),
        .stop_req  (stop_req)
    );

    discharge_sequencer discharge_sequencer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .start_req      (start_req),
        .stop_req       (stop_req),
        .sample_voltage (sample_voltage),
        .phase_en       (phase_en),
        .ip_target      (ip_target),
        .pulse_event    (pulse_event),
        .mosfet_deion   (mosfet_deion),
        .is_breakdown   (is_breakdown),
        .operation      (operation)
    );

    pulse_statistic pulse_statistic_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pulse_event (pulse_event),
        .feedback    (feedback)
    );

    // one buck controller per phase, gates go straight to the pins
    for (genvar k = 0; k < `EDM_PHASES; k++) begin : phase_gen
        buck_phase buck_phase_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .en        (phase_en[k]),
            .ip_target (ip_target),
            .current   (phase_current[k]),
            .gate      (gates[k])
        );
    end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;               // released on a falling edge like all stimulus
    end

endmodule

/* bench/edm_pulse_slave_chk.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module edm_pulse_slave_chk (
    input  logic                               clk,
    input  logic                               rst_n,
    input  edm_pkg::edm_cfg_s                  cfg,
    input  edm_pkg::gate_t [`EDM_PHASES-1:0]   gates,
    input  logic                               mosfet_deion,
    input  logic                               is_breakdown,
    input  logic                               operation
);
    import edm_pkg::*;

    int unsigned                  fail_cnt = 0;    // assertion failures so far
    time_t                        bd_len;          // cycles is_breakdown has been high
    time_t                        deion_len;       // cycles mosfet_deion has been high
    logic [`EDM_PHASES-1:0][7:0]  off_len;         // both-off run per phase, saturating

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bd_len    <= '0;
            deion_len <= '0;
            off_len   <= '0;
        end else begin
            bd_len    <= is_breakdown ? bd_len + 1'b1 : '0;
            deion_len <= mosfet_deion ? deion_len + 1'b1 : '0;
            for (int k = 0; k < `EDM_PHASES; k++) begin
                if (gates[k] != '0) begin
                    off_len[k] <= '0;
                end else if (off_len[k] != 8'hff) begin
                    off_len[k] <= off_len[k] + 8'd1;
                end
            end
        end
    end

    ton_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(is_breakdown) |-> bd_len == cfg.ton)
        else begin
            $error("error: is_breakdown high for %h cycles, cfg.ton %h",
                   $sampled(bd_len), cfg.ton);
            fail_cnt++;
        end

    toff_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mosfet_deion) |-> deion_len == cfg.toff)
        else begin
            $error("error: mosfet_deion high for %h cycles, cfg.toff %h",
                   $sampled(deion_len), cfg.toff);
            fail_cnt++;
        end

    bd_deion_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(is_breakdown && mosfet_deion))
        else begin
            $error("is_breakdown and mosfet_deion high together");
            fail_cnt++;
        end

    for (genvar k = 0; k < `EDM_PHASES; k++) begin : phase_chk
        shoot_through_a: assert property (@(posedge clk) disable iff (!rst_n)
            gates[k] != 2'b11)
            else begin
                $error("phase %0d upper and lower switch both on", k);
                fail_cnt++;
            end

        dead_time_a: assert property (@(posedge clk) disable iff (!rst_n)
            (gates[k] != '0 && gates[k] != $past(gates[k])) |->
                off_len[k] >= 8'(`EDM_DEAD_TIME))
            else begin
                $error("error: gates[%0d] switched on after %h off cycles, expected %h",
                       k, $sampled(off_len[k]), 8'(`EDM_DEAD_TIME));
                fail_cnt++;
            end

        gate_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
            (!operation || mosfet_deion) |-> gates[k] == '0)
            else begin
                $error("phase %0d gate on outside the discharge", k);
                fail_cnt++;
            end
    end

endmodule

/* bench/tb_edm_pulse_slave.sv */
`timescale 1ns/100ps
`include "edm_settings.svh"

module tb_edm_pulse_slave;
    import edm_pkg::*;

    localparam int      GAP_OPEN = 0;            // gap never breaks down
    localparam int      GAP_DELAY = 1;           // breaks down after gap_delay
    localparam int      GAP_SHORT = 2;           // gap collapsed from the start
    localparam sample_t V_HIGH = 16'd100;
    localparam sample_t V_ARC = 16'd20;          // between short and breakdown levels
    localparam int      TON_MAX = 63;
    localparam int      TOFF_MAX = 63;
    localparam int      FRAME_CYCLES = 4 + 24 * 8 + 4 + 8;
    localparam int      TIMEOUT = 50 * (TON_MAX + TOFF_MAX + `EDM_WAIT_MAX)
                                  + 40 * FRAME_CYCLES;

    logic                         clk;
    logic                         rst_n;
    logic                         sclk = 1'b0;
    logic                         cs_n = 1'b1;
    logic                         mosi = 1'b0;
    logic                         miso;
    sample_t                      sample_voltage = V_HIGH;
    sample_t [`EDM_PHASES-1:0]    phase_current = '0;
    gate_t [`EDM_PHASES-1:0]      gates;
    logic                         mosfet_deion;
    logic                         is_breakdown;
    logic                         operation;
    logic [31:0]                  rng = 32'h013eb7fa;
    int                           err_cnt = 0;
    int                           cycle_cnt = 0;
    int                           gap_mode = GAP_OPEN;
    int                           gap_delay = 0;
    int                           gap_cnt = 0;    // negedges since the wait began
    int                           deion_rises = 0;
    int                           bd_rises = 0;
    logic                         op_d = 1'b0;
    logic                         deion_d = 1'b0;
    logic                         bd_d = 1'b0;
    logic                         wait_start;

    tb_clock_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    edm_pulse_slave dut0 (
        .clk(clk), .rst_n(rst_n), .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .sample_voltage(sample_voltage), .phase_current(phase_current), .gates(gates),
        .mosfet_deion(mosfet_deion), .is_breakdown(is_breakdown), .operation(operation)
    );

    bind edm_pulse_slave edm_pulse_slave_chk chk0 (
        .clk(clk), .rst_n(rst_n), .cfg(cfg), .gates(gates), .mosfet_deion(mosfet_deion),
        .is_breakdown(is_breakdown), .operation(operation)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic string reg_name(input int addr);
        case (addr)
            0:       return "ton";
            1:       return "toff";
            default: return "ip";
        endcase
    endfunction

    // new wait after a start or at the end of a deion window
    assign wait_start = operation && (!op_d || (deion_d && !mosfet_deion));

    always @(negedge clk) begin
        if (!rst_n) begin
            gap_cnt     <= 0;
            deion_rises <= 0;
            bd_rises    <= 0;
        end else begin
            op_d    <= operation;
            deion_d <= mosfet_deion;
            bd_d    <= is_breakdown;
            if (mosfet_deion && !deion_d) deion_rises <= deion_rises + 1;
            if (is_breakdown && !bd_d) bd_rises <= bd_rises + 1;
            if (wait_start) begin
                gap_cnt <= 0;
            end else if (gap_cnt < 32'h7fff_ffff) begin
                gap_cnt <= gap_cnt + 1;
            end
            if (gap_mode == GAP_SHORT) begin
                sample_voltage <= '0;
            end else if (gap_mode == GAP_OPEN || !operation || mosfet_deion || wait_start) begin
                sample_voltage <= V_HIGH;            // gap restored
            end else begin
                sample_voltage <= (gap_cnt + 1 >= gap_delay) ? V_ARC : V_HIGH;
            end
        end
    end

    // inductor current, up while the upper switch conducts
    always @(negedge clk) begin
        for (int k = 0; k < `EDM_PHASES; k++) begin
            if (gates[k][1]) begin
                phase_current[k] <= phase_current[k] + sample_t'(3);
            end else if (phase_current[k] > sample_t'(2)) begin
                phase_current[k] <= phase_current[k] - sample_t'(2);
            end else begin
                phase_current[k] <= '0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Some tests failed");
            $finish;
        end
    end

    // frame with cs_n low, cs_n stays low afterwards
    task automatic spi_shift(input logic [23:0] tx, output logic [15:0] rx);
        rx   = '0;
        cs_n = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 23; i >= 0; i--) begin
            mosi = tx[i];
            repeat (4) @(negedge clk);
            if (i < 16) rx[i] = miso;            // settled since the last falling sclk
            sclk = 1'b1;
            repeat (4) @(negedge clk);
            sclk = 1'b0;
        end
    endtask

    task automatic spi_close();
        repeat (4) @(negedge clk);
        cs_n = 1'b1;
        repeat (8) @(negedge clk);               // write visible within 5 cycles
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [15:0] data);
        logic [15:0] rx;
        spi_shift({1'b0, addr, data}, rx);
        spi_close();
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [15:0] data);
        spi_shift({1'b1, addr, 16'h0000}, data);
        spi_close();
    endtask

    task automatic check_readback();
        logic [15:0] val;
        logic [15:0] rx;
        for (int a = 0; a < 3; a++) begin
            rng = xorshift32(rng);
            val = rng[15:0];
            spi_write(7'(a), val);
            spi_read(7'(a), rx);
            assert (rx == val) else begin
                $display("error: %s readback got %h expected %h", reg_name(a), rx, val);
                err_cnt++;
            end
        end
    endtask

    // exactly one statistic window, the stop frame is held open until pulse 15
    task automatic classify_window(input int mode, input int delay, input logic [15:0] exp_fb,
                                   input string kind);
        logic [15:0] rx;
        int          base;
        gap_mode  = mode;
        gap_delay = delay;
        rng = xorshift32(rng);
        spi_write(`EDM_ADDR_TON, 16'd16 + 16'(rng % 48));
        rng = xorshift32(rng);
        spi_write(`EDM_ADDR_TOFF, 16'd16 + 16'(rng % 48));
        base = deion_rises;
        spi_write(`EDM_ADDR_CTRL, 16'h0001);
        spi_shift({1'b0, `EDM_ADDR_CTRL, 16'h0002}, rx);
        while (deion_rises - base < `EDM_STAT_WINDOW - 1 || mosfet_deion) @(negedge clk);
        spi_close();
        while (operation) @(negedge clk);
        repeat (4) @(negedge clk);
        spi_read(`EDM_ADDR_FB, rx);
        assert (rx == exp_fb) else begin
            $display("error: feedback after %s window got %h expected %h", kind, rx, exp_fb);
            err_cnt++;
        end
    endtask

    task automatic check_single();
        int b0;
        gap_mode  = GAP_DELAY;
        gap_delay = 60;
        b0 = bd_rises;
        spi_write(`EDM_ADDR_CTRL, 16'h0005);     // single mode and start
        while (operation) @(negedge clk);
        repeat (100) @(negedge clk);
        assert (bd_rises - b0 == 1) else begin
            $display("error: is_breakdown pulses in single mode got %h expected %h",
                     bd_rises - b0, 1);
            err_cnt++;
        end
    endtask

    task automatic check_stop();
        logic [15:0] rx;
        int          b0;
        int          d0;
        b0 = bd_rises;
        spi_write(`EDM_ADDR_CTRL, 16'h0001);
        while (bd_rises - b0 < 2) @(negedge clk);
        spi_shift({1'b0, `EDM_ADDR_CTRL, 16'h0002}, rx);
        d0 = deion_rises;
        spi_close();
        while (operation) @(negedge clk);
        assert (deion_rises - d0 <= 1) else begin
            $display("error: mosfet_deion pulses after stop got %h expected at most %h",
                     deion_rises - d0, 1);
            err_cnt++;
        end
        b0 = bd_rises;
        repeat (200) @(negedge clk);
        assert (bd_rises == b0 && !operation) else begin
            $display("discharge started again after the stop write");
            err_cnt++;
        end
    endtask

    initial begin
        wait (rst_n);
        repeat (5) @(negedge clk);
        check_readback();
        spi_write(`EDM_ADDR_IP, 16'd60);
        classify_window(GAP_OPEN, 0, 16'h00f0, "open");
        classify_window(GAP_DELAY, 5, 16'h0f00, "arc");
        classify_window(GAP_DELAY, 60, 16'hf000, "normal");
        classify_window(GAP_SHORT, 0, 16'h000f, "short");
        check_single();
        check_stop();
        repeat (10) @(negedge clk);
        $display("summary: %0d compare errors, %0d assertion failures",
                 err_cnt, dut0.chk0.fail_cnt);
        if (err_cnt == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
common/edm_pkg.sv
verilog/spi_cmd_slave.sv
discharge/discharge_sequencer.sv
discharge/buck_phase.sv
verilog/pulse_statistic.sv
verilog/edm_pulse_slave.sv
bench/tb_clock_gen.sv
bench/edm_pulse_slave_chk.sv
bench/tb_edm_pulse_slave.sv

/* Bender.yml */
package:
  name: edm_pulse_slave

sources:
  - include_dirs:
      - common
    files:
      - common/edm_pkg.sv
      - verilog/spi_cmd_slave.sv
      - discharge/discharge_sequencer.sv
      - discharge/buck_phase.sv
      - verilog/pulse_statistic.sv
      - verilog/edm_pulse_slave.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_clock_gen.sv
      - bench/edm_pulse_slave_chk.sv
      - bench/tb_edm_pulse_slave.sv
